// ==== filelist.f ====
+incdir+verif
rtl/dino_pkg.sv
rtl/frame_tick.sv
rtl/dino_pose_fsm.sv
rtl/obstacle_track.sv
rtl/game_control.sv
rtl/score_bcd.sv
rtl/dino_game_top.sv
verif/dino_game_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = dino_game_tb
FILELIST = filelist.f
FLAGS    = --binary --timing --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/dino_game_model.svh ====
`ifndef DINO_GAME_MODEL_SVH
`define DINO_GAME_MODEL_SVH

// fibonacci lfsr, taps 16 14 13 11, feedback enters at bit 0
function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
    return {s[14:0], s[16-1] ^ s[14-1] ^ s[13-1] ^ s[11-1]};
endfunction

function automatic obs_kind_e kind_of(input logic [15:0] s);
    return s[15] ? BIRD : CACTUS;  // msb picks the kind
endfunction

function automatic bit collides(input obstacle_t o, input pose_t d);
    if (o.x < HIT_X_LO || o.x > HIT_X_HI)
        return 1'b0;
    return (o.kind == CACTUS) ? (d.pose != JUMP) : (d.pose != CROUCH);
endfunction

function automatic bcd_digits_t bcd_inc(input bcd_digits_t b);
    bcd_digits_t r;
    bit          carry;
    r     = b;
    carry = 1'b1;
    for (int i = 0; i < 6; i++) begin
        if (carry) begin
            carry = (r[i] == 4'd9);
            r[i]  = carry ? 4'd0 : r[i] + 4'd1;
        end
    end
    return r;
endfunction

// common anode, g..a, 0 lights a segment
function automatic seg_bank_t score_segments(input bcd_digits_t b);
    logic [6:0] lut [10];
    seg_bank_t  s;
    lut = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
    for (int i = 0; i < 6; i++)
        s[i] = (b[i] > 4'd9) ? 7'h7f : lut[b[i]];
    return s;
endfunction

// leg phase n clocks after reset release, frame k lands on clock k*FRAME_DIV+1
function automatic logic step_after(input int n);
    int frames;
    frames = (n > FRAME_DIV) ? (n - 1) / FRAME_DIV : 0;
    return ((frames / (ANIM_FRAMES + 1)) % 2) == 1;
endfunction

task automatic check_phase(input phase_e exp, input phase_e act);
    if (act !== exp) begin
        errors++;
        $display("Mismatch at %0t: phase expected %s got %s", $time, exp.name(), act.name());
    end
endtask

task automatic check_pose(input pose_e exp, input pose_t act);
    pose_e got;
    got = act.pose;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t: dino.pose expected %s got %s", $time, exp.name(), got.name());
    end
endtask

task automatic check_step(input logic exp, input pose_t act);
    if (act.step !== exp) begin
        errors++;
        $display("Mismatch at %0t: dino.step expected %b got %b", $time, exp, act.step);
    end
endtask

task automatic check_obstacle(input obstacle_t exp, input obstacle_t act);
    if (act !== exp) begin
        errors++;
        $display("Mismatch at %0t: obstacle expected x %0d kind %0d got x %0d kind %0d",
                 $time, exp.x, exp.kind, act.x, act.kind);
    end
endtask

task automatic check_hex(input seg_bank_t exp, input seg_bank_t act);
    if (act !== exp) begin
        errors++;
        $display("Mismatch at %0t: hex expected %h got %h", $time, exp, act);
    end
endtask

`endif

// ==== verif/dino_game_tb.sv ====
`timescale 1ns/100ps

module dino_game_tb;

    import dino_pkg::*;

    localparam int FRAME_DIV    = 4;
    localparam int SCORE_DIV    = 10;
    localparam int JUMP_FRAMES  = 20;
    localparam int ANIM_FRAMES  = 3;
    localparam int START_FRAMES = 8;
    localparam int STEP_FRAMES  = 2;
    localparam int LAP_CLKS     = (TRACK_LAST + 1) * (STEP_FRAMES + 1) * FRAME_DIV;

    localparam logic [4:0]  DODGE_FROM = HIT_X_LO - 5'd3;  // react three columns early
    localparam obstacle_t   OBS_HOME   = '{x: 5'd0, kind: CACTUS};
    localparam bcd_digits_t BCD_ZERO   = '0;

    logic        clk;
    logic        rst;
    logic        jump;
    logic        crouch;
    phase_e      phase;
    pose_t       dino;
    obstacle_t   obstacle;
    seg_bank_t   hex;

    int          errors;
    int          test_errs;
    int          tests;
    int          wraps;       // obstacle wraps seen so far
    int          play_clks;
    int          rst_clks;    // clocks since reset release
    logic [15:0] model_lfsr;
    bcd_digits_t exp_bcd;
    phase_e      prev_phase;
    obstacle_t   prev_obs;

    `include "dino_game_model.svh"

    dino_game_top #(
        .FRAME_DIV    (FRAME_DIV),
        .SCORE_DIV    (SCORE_DIV),
        .JUMP_FRAMES  (JUMP_FRAMES),
        .ANIM_FRAMES  (ANIM_FRAMES),
        .START_FRAMES (START_FRAMES),
        .STEP_FRAMES  (STEP_FRAMES)
    ) i_dino_game_top (
        .clk      (clk),
        .rst      (rst),
        .jump     (jump),
        .crouch   (crouch),
        .phase    (phase),
        .dino     (dino),
        .obstacle (obstacle),
        .hex      (hex)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // score and obstacle observer, mid cycle
    always @(negedge clk) begin
        obstacle_t exp_obs;
        if (rst) begin
            check_step(step_after(rst_clks), dino);
            rst_clks++;

            if (phase == PLAY && prev_phase == IDLE) begin
                play_clks = 0;
                exp_bcd   = BCD_ZERO;
            end
            check_hex(score_segments(exp_bcd), hex);
            if (phase == PLAY) begin
                play_clks++;
                if (play_clks % SCORE_DIV == 0)
                    exp_bcd = bcd_inc(exp_bcd);
            end

            exp_obs = prev_obs;
            if (prev_phase == PLAY && obstacle.x != prev_obs.x) begin
                if (prev_obs.x == TRACK_LAST) begin
                    model_lfsr   = lfsr_advance(model_lfsr);  // never reseeded
                    exp_obs.x    = 5'd0;
                    exp_obs.kind = kind_of(model_lfsr);
                    wraps++;
                end else begin
                    exp_obs.x = prev_obs.x + 5'd1;
                end
            end else if (phase == IDLE && prev_phase == IDLE) begin
                exp_obs = OBS_HOME;
            end
            check_obstacle(exp_obs, obstacle);
            prev_obs   = obstacle;
            prev_phase = phase;
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #5;
    endtask

    task automatic timed_out(input string what, input int clks);
        errors++;
        $display("%0t: timeout after %0d clocks, %s", $time, clks, what);
    endtask

    task automatic wait_phase(input phase_e target, input int limit, input string what);
        int n;
        n = 0;
        while (phase != target && n < limit) begin
            next_cycle();
            n++;
        end
        if (phase != target)
            timed_out(what, n);
    endtask

    task automatic wait_pose(input pose_e target, input int limit, input string what);
        int n;
        n = 0;
        while (dino.pose != target && n < limit) begin
            next_cycle();
            n++;
        end
        if (dino.pose != target)
            timed_out(what, n);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%0t: %s finished with %0d errors", $time, name, errors - test_errs);
        test_errs = errors;
    endtask

    // jump over cacti, duck under birds
    task automatic dodge_until(input int target);
        int n;
        n = 0;
        while (wraps < target && phase == PLAY && n < (target + 2) * LAP_CLKS) begin
            jump   = !(obstacle.kind == CACTUS && dino.pose == RUN &&
                       obstacle.x >= DODGE_FROM && obstacle.x < HIT_X_LO);
            crouch = !(obstacle.kind == BIRD &&
                       obstacle.x >= DODGE_FROM && obstacle.x <= HIT_X_HI + 5'd1);
            next_cycle();
            n++;
        end
        jump   = 1'b1;
        crouch = 1'b1;
        if (wraps < target) begin
            errors++;
            $display("%0t: obstacle wrapped only %0d of %0d times while dodging, phase %s",
                     $time, wraps, target, phase.name());
        end
    endtask

    task automatic run_into_obstacle;
        int        n;
        obstacle_t last_obs;
        pose_t     last_dino;
        obstacle_t held_obs;
        seg_bank_t held_hex;
        n         = 0;
        last_obs  = obstacle;
        last_dino = dino;
        while (phase == PLAY && n < 2 * LAP_CLKS) begin
            last_obs  = obstacle;   // values seen by the ending frame
            last_dino = dino;
            next_cycle();
            n++;
        end
        if (phase != OVER)
            timed_out("game did not end with no buttons pressed", n);
        else if (!collides(last_obs, last_dino)) begin
            errors++;
            $display("%0t: game ended with no collision, column %0d kind %0d pose %0d",
                     $time, last_obs.x, last_obs.kind, last_dino.pose);
        end
        held_obs = obstacle;
        held_hex = hex;
        repeat (10 * FRAME_DIV) begin
            next_cycle();
            check_phase(OVER, phase);
            check_obstacle(held_obs, obstacle);
            check_hex(held_hex, hex);
        end
    endtask

    task automatic restart_game;
        crouch = 1'b0;
        wait_phase(IDLE, 2 * FRAME_DIV, "press in game over did not return to idle");
        crouch = 1'b1;
        jump   = 1'b0;
        wait_phase(PLAY, 2 * FRAME_DIV, "press in idle did not start a new game");
        jump   = 1'b1;
        check_hex(score_segments(BCD_ZERO), hex);
        check_obstacle(OBS_HOME, obstacle);
    endtask

    initial begin
        int hold;
        void'($urandom(32'h957f041b));
        rst        = 1'b0;
        jump       = 1'b1;
        crouch     = 1'b1;
        errors     = 0;
        test_errs  = 0;
        tests      = 0;
        wraps      = 0;
        play_clks  = 0;
        rst_clks   = 0;
        model_lfsr = LFSR_SEED;
        exp_bcd    = BCD_ZERO;
        prev_phase = IDLE;
        prev_obs   = OBS_HOME;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b1;

        next_cycle();
        check_phase(IDLE, phase);
        check_pose(RUN, dino);
        check_obstacle(OBS_HOME, obstacle);
        check_hex(score_segments(BCD_ZERO), hex);
        jump = 1'b0;
        wait_phase(PLAY, 2 * FRAME_DIV, "jump press did not start the game");
        jump = 1'b1;
        end_test("reset and start");

        // start press also launched the jump
        for (int i = 0; i < FRAME_DIV * (JUMP_FRAMES + 1); i++) begin
            check_pose(JUMP, dino);
            next_cycle();
        end
        check_pose(RUN, dino);
        hold   = FRAME_DIV + int'($urandom % (4 * FRAME_DIV));
        crouch = 1'b0;
        wait_pose(CROUCH, 2 * FRAME_DIV, "crouch press gave no crouch");
        repeat (hold) begin
            next_cycle();
            check_pose(CROUCH, dino);
        end
        crouch = 1'b1;
        wait_pose(RUN, FRAME_DIV + 1, "dino stayed down after crouch release");
        end_test("posture");

        dodge_until(2);
        run_into_obstacle();
        end_test("obstacle, collision and score");

        restart_game();
        end_test("restart");

        dodge_until(wraps + 2);
        run_into_obstacle();
        end_test("second game");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== rtl/dino_game_top.sv ====
`timescale 1ns/100ps

module dino_game_top #(
    parameter int unsigned FRAME_DIV    = 833333,   // 60 Hz frames at 50 MHz
    parameter int unsigned SCORE_DIV    = 5000000,  // 10 points per second
    parameter int unsigned JUMP_FRAMES  = 60,
    parameter int unsigned ANIM_FRAMES  = 10,
    parameter int unsigned START_FRAMES = 120,
    parameter int unsigned STEP_FRAMES  = 5
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                jump,
    input  logic                crouch,
    output dino_pkg::phase_e    phase,
    output dino_pkg::pose_t     dino,
    output dino_pkg::obstacle_t obstacle,
    output dino_pkg::seg_bank_t hex
);

    logic frame;

    frame_tick #(.FRAME_DIV(FRAME_DIV)) i_frame_tick (
        .clk   (clk),
        .rst   (rst),
        .frame (frame)
    );

    dino_pose_fsm #(
        .JUMP_FRAMES (JUMP_FRAMES),
        .ANIM_FRAMES (ANIM_FRAMES)
    ) i_dino_pose_fsm (
        .clk    (clk),
        .rst    (rst),
        .frame  (frame),
        .jump   (jump),
        .crouch (crouch),
        .dino   (dino)
    );

    obstacle_track #(
        .START_FRAMES (START_FRAMES),
        .STEP_FRAMES  (STEP_FRAMES)
    ) i_obstacle_track (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .phase    (phase),
        .obstacle (obstacle)
    );

    game_control i_game_control (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .jump     (jump),
        .crouch   (crouch),
        .dino     (dino),
        .obstacle (obstacle),
        .phase    (phase)
    );

    score_bcd #(.SCORE_DIV(SCORE_DIV)) i_score_bcd (
        .clk   (clk),
        .rst   (rst),
        .phase (phase),
        .hex   (hex)
    );

endmodule

// ==== rtl/score_bcd.sv ====
`timescale 1ns/100ps

module score_bcd #(
    parameter int unsigned SCORE_DIV = 5000000
) (
    input  logic                clk,
    input  logic                rst,
    input  dino_pkg::phase_e    phase,
    output dino_pkg::seg_bank_t hex
);

    import dino_pkg::*;

    localparam int TW = (SCORE_DIV > 1) ? $clog2(SCORE_DIV) : 1;

    phase_e      phase_q;
    logic [TW-1:0] timer;
    logic        start;
    logic        tick;
    logic        carry;
    bcd_digits_t digits;
    bcd_digits_t digits_cur;
    bcd_digits_t digits_inc;

    assign start = (phase == PLAY) && (phase_q == IDLE);
    assign tick  = (phase == PLAY) && (timer == TW'(SCORE_DIV - 1));

    // new game shows zero right away
    assign digits_cur = start ? '0 : digits;

    // ripple carry, 999999 wraps to 0
    always_comb begin
        digits_inc = digits_cur;
        carry      = 1'b1;
        for (int i = 0; i < 6; i++) begin
            if (carry) begin
                if (digits_cur[i] == 4'd9) begin
                    digits_inc[i] = 4'd0;
                end else begin
                    digits_inc[i] = digits_cur[i] + 4'd1;
                    carry         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase_q <= IDLE;
            timer   <= '0;
            digits  <= '0;
        end else begin
            phase_q <= phase;
            if (phase != PLAY || tick)
                timer <= '0;
            else
                timer <= timer + 1'b1;
            digits <= tick ? digits_inc : digits_cur;
        end
    end

    for (genvar i = 0; i < 6; i++) begin : g_seg
        assign hex[i] = seg_encode(digits_cur[i]);
    end

endmodule

// ==== rtl/game_control.sv ====
`timescale 1ns/100ps

module game_control (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame,
    input  logic                jump,
    input  logic                crouch,
    input  dino_pkg::pose_t     dino,
    input  dino_pkg::obstacle_t obstacle,
    output dino_pkg::phase_e    phase
);

    import dino_pkg::*;

    logic in_window;
    logic hit;
    logic button;

    assign button    = !jump || !crouch;
    assign in_window = (obstacle.x >= HIT_X_LO) && (obstacle.x <= HIT_X_HI);

    // jumping clears a cactus, crouching ducks under a bird
    assign hit = in_window &&
                 (((obstacle.kind == CACTUS) && (dino.pose != JUMP)) ||
                  ((obstacle.kind == BIRD) && (dino.pose != CROUCH)));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= IDLE;
        end else if (frame) begin
            case (phase)
                IDLE: begin
                    if (button)
                        phase <= PLAY;
                end
                PLAY: begin
                    if (hit)
                        phase <= OVER;
                end
                OVER: begin
                    if (button)
                        phase <= IDLE;  // back to start screen
                end
                default: phase <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/obstacle_track.sv ====
`timescale 1ns/100ps

module obstacle_track #(
    parameter int unsigned START_FRAMES = 120,
    parameter int unsigned STEP_FRAMES  = 5
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame,
    input  dino_pkg::phase_e    phase,
    output dino_pkg::obstacle_t obstacle
);

    import dino_pkg::*;

    localparam int DW = (START_FRAMES > 0) ? $clog2(START_FRAMES + 1) : 1;
    localparam int SW = (STEP_FRAMES > 0) ? $clog2(STEP_FRAMES + 1) : 1;

    logic [DW-1:0] delay_cnt;
    logic [SW-1:0] step_cnt;
    logic          running;    // start delay done
    logic [15:0]   lfsr;
    logic [15:0]   lfsr_next;

    // fibonacci, taps 16 14 13 11
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            obstacle  <= '{x: 5'd0, kind: CACTUS};
            delay_cnt <= '0;
            step_cnt  <= '0;
            running   <= 1'b0;
            lfsr      <= LFSR_SEED;
        end else begin
            case (phase)
                IDLE: begin
                    obstacle  <= '{x: 5'd0, kind: CACTUS};
                    delay_cnt <= '0;
                    step_cnt  <= '0;
                    running   <= 1'b0;
                end
                PLAY: begin
                    if (frame && !running) begin
                        if (delay_cnt == DW'(START_FRAMES)) begin
                            delay_cnt <= '0;
                            running   <= 1'b1;
                        end else begin
                            delay_cnt <= delay_cnt + 1'b1;
                        end
                    end else if (frame) begin
                        if (step_cnt == SW'(STEP_FRAMES)) begin
                            step_cnt <= '0;
                            if (obstacle.x == TRACK_LAST) begin
                                // new obstacle enters at column 0
                                obstacle.x    <= 5'd0;
                                obstacle.kind <= obs_kind_e'(lfsr_next[15]);
                                lfsr          <= lfsr_next;
                            end else begin
                                obstacle.x <= obstacle.x + 5'd1;
                            end
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end
                default: ;  // frozen in OVER
            endcase
        end
    end

endmodule

// ==== rtl/dino_pose_fsm.sv ====
`timescale 1ns/100ps

module dino_pose_fsm #(
    parameter int unsigned JUMP_FRAMES = 60,
    parameter int unsigned ANIM_FRAMES = 10
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            frame,
    input  logic            jump,    // low when pressed
    input  logic            crouch,  // low when pressed
    output dino_pkg::pose_t dino
);

    import dino_pkg::*;

    localparam int JW = (JUMP_FRAMES > 0) ? $clog2(JUMP_FRAMES + 1) : 1;
    localparam int AW = (ANIM_FRAMES > 0) ? $clog2(ANIM_FRAMES + 1) : 1;

    logic [JW-1:0] hold_cnt;
    logic [AW-1:0] anim_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dino     <= '{pose: RUN, step: 1'b0};
            hold_cnt <= '0;
            anim_cnt <= '0;
        end else if (frame) begin
            // free running leg animation
            if (anim_cnt == AW'(ANIM_FRAMES)) begin
                anim_cnt  <= '0;
                dino.step <= ~dino.step;
            end else begin
                anim_cnt <= anim_cnt + 1'b1;
            end

            case (dino.pose)
                RUN: begin
                    if (!jump)
                        dino.pose <= JUMP;
                    else if (!crouch)
                        dino.pose <= CROUCH;
                end
                JUMP: begin
                    if (hold_cnt == JW'(JUMP_FRAMES)) begin
                        hold_cnt  <= '0;
                        dino.pose <= RUN;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                CROUCH: begin
                    if (crouch)
                        dino.pose <= RUN;  // released
                end
                default: dino.pose <= RUN;
            endcase
        end
    end

endmodule

// ==== rtl/frame_tick.sv ====
`timescale 1ns/100ps

module frame_tick #(
    parameter int unsigned FRAME_DIV = 833333
) (
    input  logic clk,
    input  logic rst,
    output logic frame
);

    localparam int CW = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt   <= '0;
            frame <= 1'b0;
        end else if (cnt == CW'(FRAME_DIV - 1)) begin
            cnt   <= '0;
            frame <= 1'b1;  // one clock wide
        end else begin
            cnt   <= cnt + 1'b1;
            frame <= 1'b0;
        end
    end

endmodule

// ==== rtl/dino_pkg.sv ====
package dino_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        PLAY = 2'd1,
        OVER = 2'd2
    } phase_e;

    typedef enum logic [1:0] {
        RUN    = 2'd0,
        JUMP   = 2'd1,
        CROUCH = 2'd2
    } pose_e;

    typedef struct packed {
        pose_e pose;
        logic  step;     // animation phase
    } pose_t;

    typedef enum logic {
        CACTUS = 1'b0,
        BIRD   = 1'b1
    } obs_kind_e;

    typedef struct packed {
        logic [4:0] x;   // track column
        obs_kind_e  kind;
    } obstacle_t;

    typedef logic [5:0][3:0] bcd_digits_t;  // digit 0 is lsd
    typedef logic [5:0][6:0] seg_bank_t;    // g..a, active low

    localparam logic [4:0]  TRACK_LAST = 5'd31;
    localparam logic [4:0]  HIT_X_LO   = 5'd12;
    localparam logic [4:0]  HIT_X_HI   = 5'd14;
    localparam logic [15:0] LFSR_SEED  = 16'hACE1;

    // common anode, lit on 0
    function automatic logic [6:0] seg_encode(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;  // blank
        endcase
    endfunction

endpackage
